//--- verilog.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_line_ram.sv
hdl/dcache_line_state.sv
hdl/dcache_word_merge.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

//--- Makefile
TOP := dcache_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int TIMEOUT    = 200;
    localparam int L2_WORDS   = 256;
    localparam int LINE_WORDS = 4;

    typedef struct packed {
        dcache_pkg::dcache_op_e op;
        dcache_pkg::amo_op_e    amo;
        logic [31:0]            addr;
        dcache_pkg::word_t      wdata;
        logic [3:0]             wstrb;
        dcache_pkg::word_t      expect_rdata;
        logic                   hit;
    } row_t;

    logic                    CLK;
    logic                    RST;
    dcache_pkg::dcache_req_t req;
    logic                    req_valid;
    logic                    ready;
    logic                    resp_valid;
    dcache_pkg::word_t       resp_rdata;
    dcache_pkg::l2_rd_req_t  l2_rd;
    logic                    fill_valid;
    dcache_pkg::line_t       fill_data;
    dcache_pkg::l2_wr_req_t  l2_wr;
    logic                    wb_done;

    dcache_pkg::word_t l2_mem [L2_WORDS];
    logic [15:0]       lfsr;
    row_t              rows [$];
    int                errors;
    int                rows_failed;
    int                wb_count;
    logic              timed_out;

    dcache_top i_dut (
        .CLK        (CLK),
        .RST        (RST),
        .req        (req),
        .req_valid  (req_valid),
        .ready      (ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .l2_rd      (l2_rd),
        .fill_valid (fill_valid),
        .fill_data  (fill_data),
        .l2_wr      (l2_wr),
        .wb_done    (wb_done)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // Three LFSR bits give an L2 delay of 1 to 8 cycles
    task automatic draw_delay(output int d);
        d = 1;
        for (int i = 0; i < 3; i++)
        begin
            d = d + (int'(lfsr[0]) << i);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int l2_base(input dcache_pkg::line_addr_t line_addr);
        return int'(line_addr) * LINE_WORDS;
    endfunction

    initial
    begin : l2_model
        int delay;
        int base;
        fill_valid = 1'b0;
        fill_data  = '0;
        wb_done    = 1'b0;
        wb_count   = 0;
        lfsr       = 16'd24;
        for (int i = 0; i < L2_WORDS; i++)
        begin
            l2_mem[i] = 32'h1000_0000 + 32'(i * 4);
        end
        forever
        begin
            @(negedge CLK);
            fill_valid = 1'b0;
            wb_done    = 1'b0;
            if (!RST && l2_wr.valid)
            begin
                base = l2_base(l2_wr.line_addr);
                if (base + LINE_WORDS > L2_WORDS)
                begin
                    $display("L2 write to line 0x%07h is outside the model", l2_wr.line_addr);
                    errors++;
                end
                else
                begin
                    for (int w = 0; w < LINE_WORDS; w++)
                    begin
                        l2_mem[base + w] = l2_wr.data[w*32 +: 32];
                    end
                end
                wb_count++;
                draw_delay(delay);
                repeat (delay - 1) @(negedge CLK);
                wb_done = 1'b1;
            end
            else if (!RST && l2_rd.valid)
            begin
                base = l2_base(l2_rd.line_addr);
                fill_data = '0;
                if (base + LINE_WORDS > L2_WORDS)
                begin
                    $display("L2 read of line 0x%07h is outside the model", l2_rd.line_addr);
                    errors++;
                end
                else
                begin
                    for (int w = 0; w < LINE_WORDS; w++)
                    begin
                        fill_data[w*32 +: 32] = l2_mem[base + w];
                    end
                end
                draw_delay(delay);
                repeat (delay - 1) @(negedge CLK);
                fill_valid = 1'b1;
            end
        end
    end

    task automatic add_row(input dcache_pkg::dcache_op_e op, input dcache_pkg::amo_op_e amo,
                           input logic [31:0] addr, input dcache_pkg::word_t wdata,
                           input logic [3:0] wstrb, input dcache_pkg::word_t expect_rdata,
                           input logic hit);
        rows.push_back('{op, amo, addr, wdata, wstrb, expect_rdata, hit});
    endtask

    task automatic add_load(input logic [31:0] addr, input dcache_pkg::word_t expect_rdata,
                            input logic hit);
        add_row(dcache_pkg::op_load, dcache_pkg::amo_swap, addr, '0, 4'h0, expect_rdata, hit);
    endtask

    task automatic add_amo(input dcache_pkg::amo_op_e amo, input logic [31:0] addr,
                           input dcache_pkg::word_t wdata, input dcache_pkg::word_t old_word);
        add_row(dcache_pkg::op_amo, amo, addr, wdata, 4'hF, old_word, 1'b1);
    endtask

    // Index 1 with tag 0, then tag 1 to force the eviction
    task automatic build_table();
        add_load(32'h010, 32'h1000_0010, 1'b0);
        add_load(32'h014, 32'h1000_0014, 1'b1);
        add_row(dcache_pkg::op_store, dcache_pkg::amo_swap, 32'h018, 32'hAABB_CCDD, 4'b0101,
                32'h1000_0018, 1'b1);
        add_load(32'h018, 32'h10BB_00DD, 1'b1);
        add_amo(dcache_pkg::amo_swap, 32'h01C, 32'h0000_0005, 32'h1000_001C);
        add_load(32'h01C, 32'h0000_0005, 1'b1);
        add_amo(dcache_pkg::amo_add, 32'h01C, 32'h0000_0010, 32'h0000_0005);
        add_load(32'h01C, 32'h0000_0015, 1'b1);
        add_amo(dcache_pkg::amo_xor, 32'h01C, 32'h0000_00FF, 32'h0000_0015);
        add_load(32'h01C, 32'h0000_00EA, 1'b1);
        add_amo(dcache_pkg::amo_or, 32'h01C, 32'h0F00_0000, 32'h0000_00EA);
        add_load(32'h01C, 32'h0F00_00EA, 1'b1);
        add_amo(dcache_pkg::amo_and, 32'h01C, 32'h0F0F_00F0, 32'h0F00_00EA);
        add_load(32'h01C, 32'h0F00_00E0, 1'b1);
        add_amo(dcache_pkg::amo_min, 32'h01C, 32'hFFFF_FF00, 32'h0F00_00E0);
        add_load(32'h01C, 32'hFFFF_FF00, 1'b1);
        add_amo(dcache_pkg::amo_max, 32'h01C, 32'h0000_0007, 32'hFFFF_FF00);
        add_load(32'h01C, 32'h0000_0007, 1'b1);
        add_amo(dcache_pkg::amo_minu, 32'h01C, 32'hFFFF_FFF0, 32'h0000_0007);
        add_load(32'h01C, 32'h0000_0007, 1'b1);
        add_amo(dcache_pkg::amo_maxu, 32'h01C, 32'h8000_0000, 32'h0000_0007);
        add_load(32'h01C, 32'h8000_0000, 1'b1);
        add_load(32'h110, 32'h1000_0110, 1'b0);
        add_load(32'h118, 32'h1000_0118, 1'b1);
        add_load(32'h018, 32'h10BB_00DD, 1'b0);
        add_load(32'h01C, 32'h8000_0000, 1'b1);
        add_load(32'h014, 32'h1000_0014, 1'b1);
    endtask

    task automatic run_row(input int n, input row_t r);
        int wait_cycles;
        int latency;
        int start_errors;
        start_errors = errors;
        wait_cycles = 0;
        while (!ready && wait_cycles < TIMEOUT)
        begin
            @(negedge CLK);
            wait_cycles++;
        end
        if (!ready)
        begin
            $display("row %0d: cache did not become ready within %0d cycles", n, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
        else
        begin
            req.addr  = r.addr;
            req.op    = r.op;
            req.amo   = r.amo;
            req.wdata = r.wdata;
            req.wstrb = r.wstrb;
            req_valid = 1'b1;
            @(posedge CLK);
            @(negedge CLK);
            req_valid = 1'b0;
            latency = 1;
            while (!resp_valid && latency < TIMEOUT)
            begin
                @(negedge CLK);
                latency++;
            end
            if (!resp_valid)
            begin
                $display("row %0d: no response within %0d cycles", n, TIMEOUT);
                errors++;
                timed_out = 1'b1;
            end
            else
            begin
                if (resp_rdata !== r.expect_rdata)
                begin
                    $display("FAILED resp_rdata: got 0x%08h, expected 0x%08h",
                             resp_rdata, r.expect_rdata);
                    errors++;
                end
                if (r.hit && latency != 2)
                begin
                    $display("row %0d: hit answered after %0d cycles instead of 2", n, latency);
                    errors++;
                end
            end
        end
        if (errors != start_errors)
        begin
            rows_failed++;
        end
        $display("row %0d %s addr 0x%08h: %s", n, r.op.name(), r.addr,
                 (errors == start_errors) ? "ok" : "failed");
    endtask

    initial
    begin : main
        int start_errors;
        RST         = 1'b1;
        req         = '0;
        req_valid   = 1'b0;
        errors      = 0;
        rows_failed = 0;
        timed_out   = 1'b0;
        build_table();
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        @(negedge CLK);
        if (ready !== 1'b1)
        begin
            $display("FAILED ready: got 0x%0h, expected 0x1", ready);
            errors++;
        end
        if (l2_rd.valid !== 1'b0)
        begin
            $display("FAILED l2_rd.valid: got 0x%0h, expected 0x0", l2_rd.valid);
            errors++;
        end
        if (l2_wr.valid !== 1'b0)
        begin
            $display("FAILED l2_wr.valid: got 0x%0h, expected 0x0", l2_wr.valid);
            errors++;
        end
        if (resp_valid !== 1'b0)
        begin
            $display("FAILED resp_valid: got 0x%0h, expected 0x0", resp_valid);
            errors++;
        end
        $display("reset state: %s", (errors == 0) ? "ok" : "failed");
        for (int n = 0; n < rows.size() && !timed_out; n++)
        begin
            run_row(n, rows[n]);
        end
        if (!timed_out)
        begin
            start_errors = errors;
            // The evicted line must carry the store and the last atomic result
            if (l2_mem[6] !== 32'h10BB_00DD)
            begin
                $display("FAILED l2_mem[0x018]: got 0x%08h, expected 0x10bb00dd", l2_mem[6]);
                errors++;
            end
            if (l2_mem[7] !== 32'h8000_0000)
            begin
                $display("FAILED l2_mem[0x01c]: got 0x%08h, expected 0x80000000", l2_mem[7]);
                errors++;
            end
            if (wb_count != 1)
            begin
                $display("FAILED wb_count: got 0x%0h, expected 0x1", wb_count);
                errors++;
            end
            $display("write-back contents: %s", (errors == start_errors) ? "ok" : "failed");
        end
        $display("rows: %0d, failed rows: %0d, errors: %0d", rows.size(), rows_failed, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
    input wire logic                   CLK,
    input wire logic                   RST,
    input wire logic                   ready,
    input wire logic                   resp_valid,
    input wire dcache_pkg::l2_rd_req_t l2_rd,
    input wire dcache_pkg::l2_wr_req_t l2_wr,
    input wire logic                   wb_done
);

    // The cache talks to L2 through one channel at a time
    a_one_l2_request: assert property (@(posedge CLK) disable iff (RST)
        !(l2_rd.valid && l2_wr.valid))
        else $error("L2 read and write requests are valid together");

    a_wr_stable: assert property (@(posedge CLK) disable iff (RST)
        (l2_wr.valid && !wb_done) |=> $stable(l2_wr))
        else $error("L2 write request changed before wb_done");

    a_resp_pulse: assert property (@(posedge CLK) disable iff (RST)
        resp_valid |=> !resp_valid)
        else $error("resp_valid stayed high for two cycles");

    a_ready_low: assert property (@(posedge CLK) disable iff (RST)
        resp_valid |-> !ready)
        else $error("ready is high while resp_valid is high");

endmodule

bind dcache_top dcache_checker i_checker (
    .CLK        (CLK),
    .RST        (RST),
    .ready      (ready),
    .resp_valid (resp_valid),
    .l2_rd      (l2_rd),
    .l2_wr      (l2_wr),
    .wb_done    (wb_done)
);

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire dcache_pkg::dcache_req_t req,
    input  wire logic                    req_valid,
    output logic                         ready,
    output logic                         resp_valid,
    output dcache_pkg::word_t            resp_rdata,
    output dcache_pkg::l2_rd_req_t       l2_rd,
    input  wire logic                    fill_valid,
    input  wire dcache_pkg::line_t       fill_data,
    output dcache_pkg::l2_wr_req_t       l2_wr,
    input  wire logic                    wb_done
);

    dcache_pkg::index_t      ram_index;
    dcache_pkg::tag_t        tag_rdata;
    dcache_pkg::line_t       line_rdata;
    dcache_pkg::line_t       merged_line;
    dcache_pkg::line_t       line_wdata;
    dcache_pkg::dcache_req_t req_q;
    logic                    valid;
    logic                    dirty;
    logic                    line_wren;
    logic                    tag_wren;
    logic                    set_valid;
    logic                    set_dirty;
    logic                    clear_dirty;

    dcache_ctrl i_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .req         (req),
        .req_valid   (req_valid),
        .ready       (ready),
        .resp_valid  (resp_valid),
        .ram_index   (ram_index),
        .tag_rdata   (tag_rdata),
        .valid       (valid),
        .dirty       (dirty),
        .line_rdata  (line_rdata),
        .merged_line (merged_line),
        .line_wren   (line_wren),
        .line_wdata  (line_wdata),
        .tag_wren    (tag_wren),
        .set_valid   (set_valid),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty),
        .l2_rd       (l2_rd),
        .l2_wr       (l2_wr),
        .fill_valid  (fill_valid),
        .fill_data   (fill_data),
        .wb_done     (wb_done),
        .req_q       (req_q)
    );

    dcache_line_ram #(
        .payload_t (dcache_pkg::line_t),
        .DEPTH     (`DCACHE_DEPTH)
    ) i_data_ram (
        .CLK   (CLK),
        .wren  (line_wren),
        .waddr (ram_index),
        .raddr (ram_index),
        .wdata (line_wdata),
        .rdata (line_rdata)
    );

    dcache_line_ram #(
        .payload_t (dcache_pkg::tag_t),
        .DEPTH     (`DCACHE_DEPTH)
    ) i_tag_ram (
        .CLK   (CLK),
        .wren  (tag_wren),
        .waddr (ram_index),
        .raddr (ram_index),
        .wdata (req_q.addr[`DCACHE_ADDR_WIDTH-1 -: `DCACHE_TAG_BITS]),
        .rdata (tag_rdata)
    );

    dcache_line_state i_line_state (
        .CLK         (CLK),
        .RST         (RST),
        .raddr       (ram_index),
        .waddr       (ram_index),
        .set_valid   (set_valid),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty),
        .valid       (valid),
        .dirty       (dirty)
    );

    dcache_word_merge i_word_merge (
        .req      (req_q),
        .line_in  (line_rdata),
        .old_word (resp_rdata),
        .line_out (merged_line)
    );

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire dcache_pkg::dcache_req_t req,
    input  wire logic                    req_valid,
    output logic                         ready,
    output logic                         resp_valid,
    output dcache_pkg::index_t           ram_index,
    input  wire dcache_pkg::tag_t        tag_rdata,
    input  wire logic                    valid,
    input  wire logic                    dirty,
    input  wire dcache_pkg::line_t       line_rdata,
    input  wire dcache_pkg::line_t       merged_line,
    output logic                         line_wren,
    output dcache_pkg::line_t            line_wdata,
    output logic                         tag_wren,
    output logic                         set_valid,
    output logic                         set_dirty,
    output logic                         clear_dirty,
    output dcache_pkg::l2_rd_req_t       l2_rd,
    output dcache_pkg::l2_wr_req_t       l2_wr,
    input  wire logic                    fill_valid,
    input  wire dcache_pkg::line_t       fill_data,
    input  wire logic                    wb_done,
    output dcache_pkg::dcache_req_t      req_q
);

    typedef enum logic [2:0]
    {
        st_idle,
        st_lookup,
        st_wb,
        st_refill,
        st_done
    } state_e;

    state_e                 state;
    dcache_pkg::tag_t       req_tag;
    dcache_pkg::index_t     req_index;
    dcache_pkg::line_addr_t victim_addr;
    dcache_pkg::line_addr_t refill_addr;
    logic                   hit;
    logic                   fill_write;
    logic                   modify;

    assign req_tag   = req_q.addr[`DCACHE_ADDR_WIDTH-1 -: `DCACHE_TAG_BITS];
    assign req_index = req_q.addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];

    assign victim_addr = {tag_rdata, req_index};
    assign refill_addr = {req_tag, req_index};

    assign hit        = valid && (tag_rdata == req_tag);
    assign fill_write = (state == st_refill) && fill_valid;
    assign modify     = (state == st_done) && (req_q.op != dcache_pkg::op_load);

    assign ready      = (state == st_idle);
    assign resp_valid = (state == st_done);

    // While idle the RAMs read at the incoming index so the lookup follows the accept edge
    assign ram_index = (state == st_idle) ?
                       req.addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS] : req_index;

    assign line_wren   = fill_write || modify;
    assign line_wdata  = fill_write ? fill_data : merged_line;
    assign tag_wren    = fill_write;
    assign set_valid   = fill_write;
    assign clear_dirty = fill_write;
    assign set_dirty   = modify;

    always_ff @(posedge CLK)
    begin
        if (ready && req_valid)
        begin
            req_q <= req;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            state       <= st_idle;
            l2_rd.valid <= 1'b0;
            l2_wr.valid <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (req_valid)
                    begin
                        state <= st_lookup;
                    end
                end
                st_lookup:
                begin
                    if (hit)
                    begin
                        state <= st_done;
                    end
                    else if (valid && dirty)
                    begin
                        // Dirty victim goes out first and the refill waits for it
                        l2_wr.valid     <= 1'b1;
                        l2_wr.line_addr <= victim_addr;
                        l2_wr.data      <= line_rdata;
                        state           <= st_wb;
                    end
                    else
                    begin
                        l2_rd.valid     <= 1'b1;
                        l2_rd.line_addr <= refill_addr;
                        state           <= st_refill;
                    end
                end
                st_wb:
                begin
                    if (wb_done)
                    begin
                        l2_wr.valid     <= 1'b0;
                        l2_rd.valid     <= 1'b1;
                        l2_rd.line_addr <= refill_addr;
                        state           <= st_refill;
                    end
                end
                st_refill:
                begin
                    // The fill is written on this edge and the request is looked up again
                    if (fill_valid)
                    begin
                        l2_rd.valid <= 1'b0;
                        state       <= st_lookup;
                    end
                end
                st_done:
                begin
                    state <= st_idle;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/dcache_word_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_word_merge (
    input  wire dcache_pkg::dcache_req_t req,
    input  wire dcache_pkg::line_t       line_in,
    output dcache_pkg::word_t            old_word,
    output dcache_pkg::line_t            line_out
);

    localparam int W = `DCACHE_DATA_WIDTH;

    logic [`DCACHE_WORD_BITS-1:0] word_sel;
    dcache_pkg::word_t            new_word;

    assign word_sel = req.addr[`DCACHE_BYTE_BITS +: `DCACHE_WORD_BITS];
    assign old_word = line_in[word_sel*W +: W];

    always_comb
    begin
        new_word = old_word;
        case (req.op)
            dcache_pkg::op_store:
            begin
                // Only the strobed bytes take the store data
                for (int b = 0; b < `DCACHE_STRB_WIDTH; b++)
                begin
                    if (req.wstrb[b])
                    begin
                        new_word[b*8 +: 8] = req.wdata[b*8 +: 8];
                    end
                end
            end
            dcache_pkg::op_amo:
            begin
                case (req.amo)
                    dcache_pkg::amo_swap: new_word = req.wdata;
                    dcache_pkg::amo_add:  new_word = req.wdata + old_word;
                    dcache_pkg::amo_xor:  new_word = req.wdata ^ old_word;
                    dcache_pkg::amo_or:   new_word = req.wdata | old_word;
                    dcache_pkg::amo_and:  new_word = req.wdata & old_word;
                    dcache_pkg::amo_min:
                        new_word = ($signed(req.wdata) < $signed(old_word)) ? req.wdata : old_word;
                    dcache_pkg::amo_max:
                        new_word = ($signed(req.wdata) > $signed(old_word)) ? req.wdata : old_word;
                    dcache_pkg::amo_minu:
                        new_word = (req.wdata < old_word) ? req.wdata : old_word;
                    dcache_pkg::amo_maxu:
                        new_word = (req.wdata > old_word) ? req.wdata : old_word;
                    default: new_word = old_word;
                endcase
            end
            default:
            begin
                new_word = old_word;
            end
        endcase
    end

    always_comb
    begin
        line_out = line_in;
        line_out[word_sel*W +: W] = new_word;
    end

endmodule

`default_nettype wire

//--- hdl/dcache_line_state.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_line_state (
    input  wire logic               CLK,
    input  wire logic               RST,
    input  wire dcache_pkg::index_t raddr,
    input  wire dcache_pkg::index_t waddr,
    input  wire logic               set_valid,
    input  wire logic               set_dirty,
    input  wire logic               clear_dirty,
    output logic                    valid,
    output logic                    dirty
);

    logic [`DCACHE_DEPTH-1:0] valid_q;
    logic [`DCACHE_DEPTH-1:0] dirty_q;
    logic                     same_line;

    assign same_line = (waddr == raddr);

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            valid   <= 1'b0;
            dirty   <= 1'b0;
        end
        else
        begin
            if (set_valid)
            begin
                valid_q[waddr] <= 1'b1;
            end
            if (set_dirty)
            begin
                dirty_q[waddr] <= 1'b1;
            end
            else if (clear_dirty)
            begin
                dirty_q[waddr] <= 1'b0;
            end
            // Same write-first behavior as the RAMs keeps the bits aligned with the tag
            valid <= (same_line && set_valid) ? 1'b1 : valid_q[raddr];
            if (same_line && set_dirty)
            begin
                dirty <= 1'b1;
            end
            else if (same_line && clear_dirty)
            begin
                dirty <= 1'b0;
            end
            else
            begin
                dirty <= dirty_q[raddr];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dcache_line_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_line_ram #(
    parameter type payload_t = dcache_pkg::line_t,
    parameter int  DEPTH     = `DCACHE_DEPTH
) (
    input  wire logic               CLK,
    input  wire logic               wren,
    input  wire dcache_pkg::index_t waddr,
    input  wire dcache_pkg::index_t raddr,
    input  wire payload_t           wdata,
    output payload_t                rdata
);

    payload_t mem [DEPTH];

    // Write-first, so a line filled on this edge is visible on the next lookup
    always_ff @(posedge CLK)
    begin
        if (wren)
        begin
            mem[waddr] <= wdata;
        end
        rdata <= (wren && (waddr == raddr)) ? wdata : mem[raddr];
    end

endmodule

`default_nettype wire

//--- hdl/dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    typedef enum logic [1:0]
    {
        op_load,
        op_store,
        op_amo
    } dcache_op_e;

    typedef enum logic [3:0]
    {
        amo_swap,
        amo_add,
        amo_xor,
        amo_or,
        amo_and,
        amo_min,
        amo_max,
        amo_minu,
        amo_maxu
    } amo_op_e;

    typedef logic [`DCACHE_DATA_WIDTH-1:0] word_t;
    typedef logic [`DCACHE_LINE_WIDTH-1:0] line_t;
    typedef logic [`DCACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`DCACHE_LINE_ADDR_BITS-1:0] line_addr_t;

    typedef struct packed {
        logic [`DCACHE_ADDR_WIDTH-1:0] addr;
        dcache_op_e                    op;
        amo_op_e                       amo;
        word_t                         wdata;
        logic [`DCACHE_STRB_WIDTH-1:0] wstrb;
    } dcache_req_t;

    typedef struct packed {
        logic       valid;
        line_addr_t line_addr;
    } l2_rd_req_t;

    typedef struct packed {
        logic       valid;
        line_addr_t line_addr;
        line_t      data;
    } l2_wr_req_t;

endpackage

`default_nettype wire

//--- hdl/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Basic geometry of the cache
`define DCACHE_DATA_WIDTH 32
`define DCACHE_ADDR_WIDTH 32
`define DCACHE_LINE_WORDS 4
`define DCACHE_DEPTH 16

// Derived widths
`define DCACHE_LINE_WIDTH (`DCACHE_DATA_WIDTH * `DCACHE_LINE_WORDS)
`define DCACHE_STRB_WIDTH (`DCACHE_DATA_WIDTH / 8)
`define DCACHE_BYTE_BITS ($clog2(`DCACHE_STRB_WIDTH))
`define DCACHE_WORD_BITS ($clog2(`DCACHE_LINE_WORDS))
`define DCACHE_OFFSET_BITS (`DCACHE_BYTE_BITS + `DCACHE_WORD_BITS)
`define DCACHE_INDEX_BITS ($clog2(`DCACHE_DEPTH))
`define DCACHE_TAG_BITS (`DCACHE_ADDR_WIDTH - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)

// Address as seen by L2, without the byte offset inside a line
`define DCACHE_LINE_ADDR_BITS (`DCACHE_ADDR_WIDTH - `DCACHE_OFFSET_BITS)

`endif
